/* sa_pkg.sv */
package sa_pkg;

    // Matrix and datapath sizes
    localparam int n           = 4;
    localparam int data_width  = 32;
    localparam int addr_width  = 13;
    localparam int total_elems = n * n;

    // Cycles from a memory request to its response or write completion
    localparam int mem_latency = 3;

    // Last run phase cycle, the one that feeds X[n-1][n-1] into row n-1
    localparam int run_last = 3 * n - 2;

    // One signed matrix element, wraps on overflow
    typedef logic signed [data_width-1:0] data_t;

    // One memory word address
    typedef logic [addr_width-1:0] addr_t;

    // Element index into a flattened row-major matrix
    typedef logic [$clog2(total_elems)-1:0] idx_t;

    // Row or column index with room to hold n itself
    typedef logic [$clog2(n):0] row_t;

    // Run phase counter, 0 to run_last
    typedef logic [$clog2(run_last+1)-1:0] phase_t;

    // Memory latency timer
    typedef logic [$clog2(mem_latency+1)-1:0] lat_t;

    typedef enum logic [3:0] {
        idle,
        load_w_req,
        load_w_wait,
        load_x_req,
        load_x_wait,
        run,
        capture,
        store_req,
        store_wait,
        finish
    } ctrl_state_t;

endpackage

/* sa_pe.sv */
`timescale 1ns/1ps

module sa_pe (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          w_shift,
    input  sa_pkg::data_t w_in,
    output sa_pkg::data_t w_out,
    input  sa_pkg::data_t x_in,
    input  logic          x_valid_in,
    output sa_pkg::data_t x_out,
    output logic          x_valid_out,
    input  sa_pkg::data_t psum_in,
    output sa_pkg::data_t psum_out,
    output logic          psum_valid
);

    sa_pkg::data_t weight;

    // Weight shifts down the column while w_shift is high, then stays put
    always_ff @(posedge clk) begin
        if (w_shift) begin
            weight <= w_in;
        end
    end

    assign w_out = weight;

    // Data path registers, the products wrap at data_width bits
    always_ff @(posedge clk) begin
        x_out    <= x_in;
        psum_out <= psum_in + weight * x_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_valid_out <= 1'b0;
            psum_valid  <= 1'b0;
        end else begin
            x_valid_out <= x_valid_in;
            psum_valid  <= x_valid_in;
        end
    end

endmodule

/* sa_array.sv */
`timescale 1ns/1ps

module sa_array (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          w_shift,
    input  sa_pkg::data_t w_col_in    [sa_pkg::n],
    input  sa_pkg::data_t x_row_in    [sa_pkg::n],
    input  logic          x_row_valid [sa_pkg::n],
    output sa_pkg::data_t col_out     [sa_pkg::n],
    output logic          col_valid   [sa_pkg::n]
);

    // Vertical links carry weights and partial sums, row index first
    sa_pkg::data_t w_link    [sa_pkg::n+1][sa_pkg::n];
    sa_pkg::data_t psum_link [sa_pkg::n+1][sa_pkg::n];
    logic          pv_link   [sa_pkg::n][sa_pkg::n];

    // Horizontal links carry the streamed X values and their valid bits
    sa_pkg::data_t x_link  [sa_pkg::n][sa_pkg::n+1];
    logic          xv_link [sa_pkg::n][sa_pkg::n+1];

    for (genvar c = 0; c < sa_pkg::n; c++) begin : g_top
        assign w_link[0][c]    = w_col_in[c];
        assign psum_link[0][c] = '0;
    end

    for (genvar r = 0; r < sa_pkg::n; r++) begin : g_left
        assign x_link[r][0]  = x_row_in[r];
        assign xv_link[r][0] = x_row_valid[r];
    end

    for (genvar r = 0; r < sa_pkg::n; r++) begin : g_row
        for (genvar c = 0; c < sa_pkg::n; c++) begin : g_col
            sa_pe pe_i (
                .clk         (clk),
                .rst_n       (rst_n),
                .w_shift     (w_shift),
                .w_in        (w_link[r][c]),
                .w_out       (w_link[r+1][c]),
                .x_in        (x_link[r][c]),
                .x_valid_in  (xv_link[r][c]),
                .x_out       (x_link[r][c+1]),
                .x_valid_out (xv_link[r][c+1]),
                .psum_in     (psum_link[r][c]),
                .psum_out    (psum_link[r+1][c]),
                .psum_valid  (pv_link[r][c])
            );
        end
    end

    // Finished sums leave at the bottom row
    for (genvar c = 0; c < sa_pkg::n; c++) begin : g_bottom
        assign col_out[c]   = psum_link[sa_pkg::n][c];
        assign col_valid[c] = pv_link[sa_pkg::n-1][c];
    end

endmodule

/* sa_operand_buffer.sv */
`timescale 1ns/1ps

module sa_operand_buffer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wr_en,
    input  logic          wr_sel_x,
    input  sa_pkg::idx_t  wr_idx,
    input  sa_pkg::data_t wr_data,
    input  sa_pkg::idx_t  w_rd_idx  [sa_pkg::n],
    input  sa_pkg::idx_t  x_rd_idx  [sa_pkg::n],
    output sa_pkg::data_t w_rd_data [sa_pkg::n],
    output sa_pkg::data_t x_rd_data [sa_pkg::n]
);

    // Row-major copies of W and X
    sa_pkg::data_t w_mem [sa_pkg::total_elems];
    sa_pkg::data_t x_mem [sa_pkg::total_elems];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < sa_pkg::total_elems; e++) begin
                w_mem[e] <= '0;
                x_mem[e] <= '0;
            end
        end else if (wr_en) begin
            if (wr_sel_x) begin
                x_mem[wr_idx] <= wr_data;
            end else begin
                w_mem[wr_idx] <= wr_data;
            end
        end
    end

    // One read lane per array column for W and per array row for X
    always_comb begin
        for (int l = 0; l < sa_pkg::n; l++) begin
            w_rd_data[l] = w_mem[w_rd_idx[l]];
            x_rd_data[l] = x_mem[x_rd_idx[l]];
        end
    end

endmodule

/* sa_result_buffer.sv */
`timescale 1ns/1ps

module sa_result_buffer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear,
    input  sa_pkg::data_t col_out   [sa_pkg::n],
    input  logic          col_valid [sa_pkg::n],
    output logic          full,
    input  sa_pkg::idx_t  rd_idx,
    output sa_pkg::data_t rd_data
);

    // P in row-major order
    sa_pkg::data_t res_mem [sa_pkg::total_elems];

    // Next row to fill, per column
    sa_pkg::row_t row_ptr [sa_pkg::n];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < sa_pkg::n; j++) begin
                row_ptr[j] <= '0;
            end
            for (int e = 0; e < sa_pkg::total_elems; e++) begin
                res_mem[e] <= '0;
            end
        end else if (clear) begin
            for (int j = 0; j < sa_pkg::n; j++) begin
                row_ptr[j] <= '0;
            end
            for (int e = 0; e < sa_pkg::total_elems; e++) begin
                res_mem[e] <= '0;
            end
        end else begin
            // Columns write disjoint entries, so all may land in one cycle
            for (int j = 0; j < sa_pkg::n; j++) begin
                if (col_valid[j] && row_ptr[j] < sa_pkg::row_t'(sa_pkg::n)) begin
                    res_mem[sa_pkg::idx_t'(int'(row_ptr[j]) * sa_pkg::n + j)] <= col_out[j];
                    row_ptr[j] <= row_ptr[j] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        full = 1'b1;
        for (int j = 0; j < sa_pkg::n; j++) begin
            if (row_ptr[j] != sa_pkg::row_t'(sa_pkg::n)) begin
                full = 1'b0;
            end
        end
    end

    assign rd_data = res_mem[rd_idx];

endmodule

/* sa_controller.sv */
`timescale 1ns/1ps

module sa_controller (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  sa_pkg::addr_t base_addr_w,
    input  sa_pkg::addr_t base_addr_x,
    input  sa_pkg::addr_t base_addr_out,
    output logic          done,
    output sa_pkg::addr_t mem_req_addr,
    output sa_pkg::data_t mem_req_data,
    output logic          mem_read_en,
    output logic          mem_write_en,
    input  sa_pkg::data_t mem_resp_data,
    output logic          opnd_wr_en,
    output logic          opnd_wr_sel_x,
    output sa_pkg::idx_t  opnd_wr_idx,
    output sa_pkg::data_t opnd_wr_data,
    output sa_pkg::idx_t  w_rd_idx    [sa_pkg::n],
    output sa_pkg::idx_t  x_rd_idx    [sa_pkg::n],
    input  sa_pkg::data_t w_rd_data   [sa_pkg::n],
    input  sa_pkg::data_t x_rd_data   [sa_pkg::n],
    output logic          w_shift,
    output sa_pkg::data_t w_col_in    [sa_pkg::n],
    output sa_pkg::data_t x_row_in    [sa_pkg::n],
    output logic          x_row_valid [sa_pkg::n],
    output logic          res_clear,
    input  logic          res_full,
    output sa_pkg::idx_t  res_rd_idx,
    input  sa_pkg::data_t res_rd_data
);

    sa_pkg::ctrl_state_t state;
    sa_pkg::addr_t       base_w_q;
    sa_pkg::addr_t       base_x_q;
    sa_pkg::addr_t       base_out_q;
    sa_pkg::idx_t        elem;
    sa_pkg::lat_t        timer;
    sa_pkg::phase_t      phase;

    logic start_ok;
    logic last_elem;
    logic lat_end;

    assign start_ok  = start && (state == sa_pkg::idle);
    assign last_elem = (elem == sa_pkg::idx_t'(sa_pkg::total_elems - 1));

    // Request goes out in the req state, response arrives mem_latency cycles later
    assign lat_end = (timer == sa_pkg::lat_t'(sa_pkg::mem_latency - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= sa_pkg::idle;
            base_w_q   <= '0;
            base_x_q   <= '0;
            base_out_q <= '0;
            elem       <= '0;
            timer      <= '0;
            phase      <= '0;
        end else begin
            case (state)
                sa_pkg::idle: begin
                    if (start) begin
                        base_w_q   <= base_addr_w;
                        base_x_q   <= base_addr_x;
                        base_out_q <= base_addr_out;
                        elem       <= '0;
                        state      <= sa_pkg::load_w_req;
                    end
                end
                sa_pkg::load_w_req: begin
                    timer <= '0;
                    state <= sa_pkg::load_w_wait;
                end
                sa_pkg::load_w_wait: begin
                    if (!lat_end) begin
                        timer <= timer + 1'b1;
                    end else if (last_elem) begin
                        elem  <= '0;
                        state <= sa_pkg::load_x_req;
                    end else begin
                        elem  <= elem + 1'b1;
                        state <= sa_pkg::load_w_req;
                    end
                end
                sa_pkg::load_x_req: begin
                    timer <= '0;
                    state <= sa_pkg::load_x_wait;
                end
                sa_pkg::load_x_wait: begin
                    if (!lat_end) begin
                        timer <= timer + 1'b1;
                    end else if (last_elem) begin
                        phase <= '0;
                        state <= sa_pkg::run;
                    end else begin
                        elem  <= elem + 1'b1;
                        state <= sa_pkg::load_x_req;
                    end
                end
                sa_pkg::run: begin
                    if (phase == sa_pkg::phase_t'(sa_pkg::run_last)) begin
                        state <= sa_pkg::capture;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                sa_pkg::capture: begin
                    // Drain the array until every column has delivered n rows
                    if (res_full) begin
                        elem  <= '0;
                        state <= sa_pkg::store_req;
                    end
                end
                sa_pkg::store_req: begin
                    timer <= '0;
                    state <= sa_pkg::store_wait;
                end
                sa_pkg::store_wait: begin
                    if (!lat_end) begin
                        timer <= timer + 1'b1;
                    end else if (last_elem) begin
                        state <= sa_pkg::finish;
                    end else begin
                        elem  <= elem + 1'b1;
                        state <= sa_pkg::store_req;
                    end
                end
                sa_pkg::finish: begin
                    state <= sa_pkg::idle;
                end
                default: begin
                    state <= sa_pkg::idle;
                end
            endcase
        end
    end

    // Memory port, address and data are zero outside a request
    always_comb begin
        mem_read_en  = 1'b0;
        mem_write_en = 1'b0;
        mem_req_addr = '0;
        mem_req_data = '0;
        case (state)
            sa_pkg::load_w_req: begin
                mem_read_en  = 1'b1;
                mem_req_addr = base_w_q + sa_pkg::addr_t'(elem);
            end
            sa_pkg::load_x_req: begin
                mem_read_en  = 1'b1;
                mem_req_addr = base_x_q + sa_pkg::addr_t'(elem);
            end
            sa_pkg::store_req: begin
                mem_write_en = 1'b1;
                mem_req_addr = base_out_q + sa_pkg::addr_t'(elem);
                mem_req_data = res_rd_data;
            end
            default: begin
            end
        endcase
    end

    // Response capture into the operand buffer
    assign opnd_wr_en    = lat_end && (state == sa_pkg::load_w_wait ||
                                       state == sa_pkg::load_x_wait);
    assign opnd_wr_sel_x = (state == sa_pkg::load_x_wait);
    assign opnd_wr_idx   = elem;
    assign opnd_wr_data  = mem_resp_data;

    assign res_clear  = start_ok;
    assign res_rd_idx = elem;
    assign done       = (state == sa_pkg::finish);

    // Weights go in bottom row first so that row k ends up holding W[k][*]
    always_comb begin
        w_shift = (state == sa_pkg::run) && (int'(phase) < sa_pkg::n);
        for (int j = 0; j < sa_pkg::n; j++) begin
            w_rd_idx[j] = '0;
            w_col_in[j] = '0;
            if (w_shift) begin
                w_rd_idx[j] = sa_pkg::idx_t'((sa_pkg::n - 1 - int'(phase)) * sa_pkg::n + j);
                w_col_in[j] = w_rd_data[j];
            end
        end
    end

    // X skew, element X[i][k] enters row k at phase n+i+k
    always_comb begin
        int xi;
        for (int k = 0; k < sa_pkg::n; k++) begin
            xi = int'(phase) - sa_pkg::n - k;
            x_rd_idx[k]    = '0;
            x_row_in[k]    = '0;
            x_row_valid[k] = 1'b0;
            if (state == sa_pkg::run && xi >= 0 && xi < sa_pkg::n) begin
                x_rd_idx[k]    = sa_pkg::idx_t'(xi * sa_pkg::n + k);
                x_row_in[k]    = x_rd_data[k];
                x_row_valid[k] = 1'b1;
            end
        end
    end

endmodule

/* sa_top.sv */
`timescale 1ns/1ps

module sa_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  sa_pkg::addr_t base_addr_w,
    input  sa_pkg::addr_t base_addr_x,
    input  sa_pkg::addr_t base_addr_out,
    output logic          done,
    output sa_pkg::addr_t mem_req_addr,
    output sa_pkg::data_t mem_req_data,
    output logic          mem_read_en,
    output logic          mem_write_en,
    input  sa_pkg::data_t mem_resp_data
);

    // Operand buffer port
    logic          opnd_wr_en;
    logic          opnd_wr_sel_x;
    sa_pkg::idx_t  opnd_wr_idx;
    sa_pkg::data_t opnd_wr_data;
    sa_pkg::idx_t  w_rd_idx  [sa_pkg::n];
    sa_pkg::idx_t  x_rd_idx  [sa_pkg::n];
    sa_pkg::data_t w_rd_data [sa_pkg::n];
    sa_pkg::data_t x_rd_data [sa_pkg::n];

    // Array feed and results
    logic          w_shift;
    sa_pkg::data_t w_col_in    [sa_pkg::n];
    sa_pkg::data_t x_row_in    [sa_pkg::n];
    logic          x_row_valid [sa_pkg::n];
    sa_pkg::data_t col_out     [sa_pkg::n];
    logic          col_valid   [sa_pkg::n];

    // Result buffer port
    logic          res_clear;
    logic          res_full;
    sa_pkg::idx_t  res_rd_idx;
    sa_pkg::data_t res_rd_data;

    sa_controller ctrl_i (
        .clk(clk), .rst_n(rst_n), .start(start),
        .base_addr_w(base_addr_w), .base_addr_x(base_addr_x), .base_addr_out(base_addr_out),
        .done(done), .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
        .mem_read_en(mem_read_en), .mem_write_en(mem_write_en), .mem_resp_data(mem_resp_data),
        .opnd_wr_en(opnd_wr_en), .opnd_wr_sel_x(opnd_wr_sel_x),
        .opnd_wr_idx(opnd_wr_idx), .opnd_wr_data(opnd_wr_data),
        .w_rd_idx(w_rd_idx), .x_rd_idx(x_rd_idx), .w_rd_data(w_rd_data), .x_rd_data(x_rd_data),
        .w_shift(w_shift), .w_col_in(w_col_in), .x_row_in(x_row_in), .x_row_valid(x_row_valid),
        .res_clear(res_clear), .res_full(res_full),
        .res_rd_idx(res_rd_idx), .res_rd_data(res_rd_data)
    );

    sa_operand_buffer opnd_i (
        .clk(clk), .rst_n(rst_n), .wr_en(opnd_wr_en), .wr_sel_x(opnd_wr_sel_x),
        .wr_idx(opnd_wr_idx), .wr_data(opnd_wr_data),
        .w_rd_idx(w_rd_idx), .x_rd_idx(x_rd_idx), .w_rd_data(w_rd_data), .x_rd_data(x_rd_data)
    );

    sa_array array_i (
        .clk(clk), .rst_n(rst_n), .w_shift(w_shift), .w_col_in(w_col_in),
        .x_row_in(x_row_in), .x_row_valid(x_row_valid),
        .col_out(col_out), .col_valid(col_valid)
    );

    sa_result_buffer res_i (
        .clk(clk), .rst_n(rst_n), .clear(res_clear),
        .col_out(col_out), .col_valid(col_valid), .full(res_full),
        .rd_idx(res_rd_idx), .rd_data(res_rd_data)
    );

endmodule

/* tb_sa_mem.sv */
`timescale 1ns/1ps

module tb_sa_mem (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          load_en,
    input  sa_pkg::addr_t load_addr,
    input  sa_pkg::data_t load_data,
    input  sa_pkg::addr_t mem_req_addr,
    input  sa_pkg::data_t mem_req_data,
    input  logic          mem_read_en,
    input  logic          mem_write_en,
    output sa_pkg::data_t mem_resp_data,
    output logic          protocol_error
);

    sa_pkg::data_t mem [2**sa_pkg::addr_width];

    // Read data pipeline, the last stage faces the DUT
    sa_pkg::data_t resp_pipe [sa_pkg::mem_latency];

    // Every write of the DUT, in order
    sa_pkg::addr_t wr_addr_log [sa_pkg::total_elems * 16];
    sa_pkg::data_t wr_data_log [sa_pkg::total_elems * 16];
    int            wr_total;

    // Cycles without a request since the last one, saturates at mem_latency
    int idle_cycles;

    assign mem_resp_data = resp_pipe[sa_pkg::mem_latency-1];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < sa_pkg::mem_latency; s++) begin
                resp_pipe[s] <= '0;
            end
            wr_total       <= 0;
            idle_cycles    <= sa_pkg::mem_latency;
            protocol_error <= 1'b0;
        end else begin
            resp_pipe[0] <= mem_read_en ? mem[mem_req_addr] : '0;
            for (int s = 1; s < sa_pkg::mem_latency; s++) begin
                resp_pipe[s] <= resp_pipe[s-1];
            end
            if (load_en) begin
                mem[load_addr] <= load_data;
            end
            if (mem_write_en) begin
                mem[mem_req_addr] <= mem_req_data;
                if (wr_total < sa_pkg::total_elems * 16) begin
                    wr_addr_log[wr_total] <= mem_req_addr;
                    wr_data_log[wr_total] <= mem_req_data;
                end
                wr_total <= wr_total + 1;
            end
            if (mem_read_en && mem_write_en) begin
                $display("memory protocol failure: a read and a write in the same cycle");
                protocol_error <= 1'b1;
            end
            if (mem_read_en || mem_write_en) begin
                if (idle_cycles < sa_pkg::mem_latency) begin
                    $display("memory protocol failure: request only %0d cycles after the last",
                             idle_cycles + 1);
                    protocol_error <= 1'b1;
                end
                idle_cycles <= 0;
            end else if (idle_cycles < sa_pkg::mem_latency) begin
                idle_cycles <= idle_cycles + 1;
            end
        end
    end

endmodule

/* tb_sa_top.sv */
`timescale 1ns/1ps

module tb_sa_top;

    logic          clk;
    logic          rst_n;
    logic          start;
    sa_pkg::addr_t base_addr_w;
    sa_pkg::addr_t base_addr_x;
    sa_pkg::addr_t base_addr_out;
    logic          done;
    sa_pkg::addr_t mem_req_addr;
    sa_pkg::data_t mem_req_data;
    logic          mem_read_en;
    logic          mem_write_en;
    sa_pkg::data_t mem_resp_data;
    logic          protocol_error;
    logic          load_en;
    sa_pkg::addr_t load_addr;
    sa_pkg::data_t load_data;

    // Copy of what was preloaded into the memory model
    sa_pkg::data_t image [2**sa_pkg::addr_width];

    // Bases of the run under check
    sa_pkg::addr_t exp_base_w;
    sa_pkg::addr_t exp_base_x;
    sa_pkg::addr_t exp_base_out;

    int rd_seen;
    int wr_seen;
    int done_seen;
    int wr_before;

    sa_top dut_i (
        .clk(clk), .rst_n(rst_n), .start(start),
        .base_addr_w(base_addr_w), .base_addr_x(base_addr_x), .base_addr_out(base_addr_out),
        .done(done), .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
        .mem_read_en(mem_read_en), .mem_write_en(mem_write_en), .mem_resp_data(mem_resp_data)
    );

    tb_sa_mem mem_i (
        .clk(clk), .rst_n(rst_n),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
        .mem_read_en(mem_read_en), .mem_write_en(mem_write_en),
        .mem_resp_data(mem_resp_data), .protocol_error(protocol_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_data(string name, sa_pkg::data_t got, sa_pkg::data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, sa_pkg::addr_t got, sa_pkg::addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // P[i][j] as the wrapping sum over k of X[i][k] * W[k][j]
    function automatic sa_pkg::data_t ref_matmul(int m);
        sa_pkg::data_t acc;
        int            i;
        int            j;
        acc = '0;
        i = m / sa_pkg::n;
        j = m % sa_pkg::n;
        for (int k = 0; k < sa_pkg::n; k++) begin
            acc = acc + image[sa_pkg::addr_t'(exp_base_w + k * sa_pkg::n + j)]
                      * image[sa_pkg::addr_t'(exp_base_x + i * sa_pkg::n + k)];
        end
        return acc;
    endfunction

    // Operands at and around the signed limits
    function automatic sa_pkg::data_t edge_value(int k);
        case (k % 8)
            0: return 32'h7fff_ffff;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return 32'h7fff_fff0;
            4: return 32'hffff_fffe;
            5: return 32'h8000_0001;
            6: return 32'h0000_0003;
            default: return 32'h4000_0000;
        endcase
    endfunction

    task automatic load_word(sa_pkg::addr_t a, sa_pkg::data_t d);
        load_en   <= 1'b1;
        load_addr <= a;
        load_data <= d;
        image[a] = d;
        @(posedge clk);
    endtask

    task automatic fill_random(sa_pkg::addr_t base);
        for (int e = 0; e < sa_pkg::total_elems; e++) begin
            load_word(base + sa_pkg::addr_t'(e), sa_pkg::data_t'($urandom));
        end
    endtask

    task automatic fill_edge(sa_pkg::addr_t base, int shift);
        for (int e = 0; e < sa_pkg::total_elems; e++) begin
            load_word(base + sa_pkg::addr_t'(e), edge_value(e + shift));
        end
    endtask

    task automatic pulse_start(sa_pkg::addr_t w, sa_pkg::addr_t x, sa_pkg::addr_t o);
        start         <= 1'b1;
        base_addr_w   <= w;
        base_addr_x   <= x;
        base_addr_out <= o;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic launch(sa_pkg::addr_t w, sa_pkg::addr_t x, sa_pkg::addr_t o);
        exp_base_w   = w;
        exp_base_x   = x;
        exp_base_out = o;
        rd_seen      = 0;
        wr_seen      = 0;
        done_seen    = 0;
        wr_before    = mem_i.wr_total;
        pulse_start(w, x, o);
    endtask

    task automatic wait_done(int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < limit) begin
            cycles++;
            @(negedge clk);
        end
        if (!done) begin
            abort_run($sformatf("timeout, no done within %0d cycles of start", limit));
        end
        @(posedge clk);
    endtask

    task automatic check_quiet(int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (done || mem_read_en || mem_write_en) begin
                abort_run("done or a memory request appeared while the accelerator was idle");
            end
        end
        @(posedge clk);
    endtask

    task automatic finish_run();
        if (rd_seen != 2 * sa_pkg::total_elems) begin
            abort_run($sformatf("run issued %0d memory reads instead of 32", rd_seen));
        end
        if (wr_seen != sa_pkg::total_elems || mem_i.wr_total - wr_before != wr_seen) begin
            abort_run($sformatf("run issued %0d memory writes instead of 16", wr_seen));
        end
        if (done_seen != 1) begin
            abort_run($sformatf("done pulsed %0d times in one run", done_seen));
        end
        for (int m = 0; m < sa_pkg::total_elems; m++) begin
            check_addr("wr_addr_log", mem_i.wr_addr_log[wr_before + m],
                       exp_base_out + sa_pkg::addr_t'(m));
            check_data("wr_data_log", mem_i.wr_data_log[wr_before + m], ref_matmul(m));
        end
    endtask

    // Bus checker sampling mid-cycle when DUT outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (protocol_error) begin
                abort_run("memory model saw a request protocol violation");
            end
            // Address and data rest at zero outside a request
            if (!mem_read_en && !mem_write_en) begin
                check_addr("mem_req_addr", mem_req_addr, '0);
            end
            if (!mem_write_en) begin
                check_data("mem_req_data", mem_req_data, '0);
            end
            if (mem_read_en) begin
                if (rd_seen < sa_pkg::total_elems) begin
                    check_addr("mem_req_addr", mem_req_addr,
                               exp_base_w + sa_pkg::addr_t'(rd_seen));
                end else begin
                    check_addr("mem_req_addr", mem_req_addr,
                               exp_base_x + sa_pkg::addr_t'(rd_seen - sa_pkg::total_elems));
                end
                rd_seen = rd_seen + 1;
            end
            if (mem_write_en) begin
                if (wr_seen >= sa_pkg::total_elems) begin
                    abort_run("more memory writes than elements in the product");
                end
                check_addr("mem_req_addr", mem_req_addr, exp_base_out + sa_pkg::addr_t'(wr_seen));
                check_data("mem_req_data", mem_req_data, ref_matmul(wr_seen));
                wr_seen = wr_seen + 1;
            end
            if (done) begin
                done_seen = done_seen + 1;
            end
        end
    end

    initial begin
        void'($urandom(32'hdb5f));
        rst_n         = 1'b0;
        start         = 1'b0;
        base_addr_w   = '0;
        base_addr_x   = '0;
        base_addr_out = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        exp_base_w    = '0;
        exp_base_x    = '0;
        exp_base_out  = '0;
        rd_seen       = 0;
        wr_seen       = 0;
        done_seen     = 0;
        wr_before     = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        check_quiet(6);

        // All operands up front and away from every output area
        fill_random(13'h000);
        fill_random(13'h100);
        fill_edge(13'h300, 0);
        fill_edge(13'h400, 3);
        fill_random(13'h600);
        fill_random(13'h700);
        fill_random(13'h900);
        fill_random(13'ha00);
        fill_random(13'hc00);
        fill_random(13'hd00);
        load_en <= 1'b0;
        @(posedge clk);

        launch(13'h000, 13'h100, 13'h200);
        wait_done(400);
        finish_run();

        // Wrapping products near the signed limits
        launch(13'h300, 13'h400, 13'h500);
        wait_done(400);
        finish_run();

        // Second run starts in the cycle after done
        launch(13'h600, 13'h700, 13'h800);
        wait_done(400);
        finish_run();
        launch(13'h900, 13'ha00, 13'hb00);
        wait_done(400);
        finish_run();

        // A start in the middle of a run must be ignored
        launch(13'hc00, 13'hd00, 13'he00);
        repeat (20) @(posedge clk);
        pulse_start(13'h1000, 13'h1100, 13'h1f00);
        wait_done(400);
        finish_run();
        check_quiet(12);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* verilog.f */
sa_pkg.sv
sa_pe.sv
sa_array.sv
sa_operand_buffer.sv
sa_result_buffer.sv
sa_controller.sv
sa_top.sv
tb_sa_mem.sv
tb_sa_top.sv

/* run.sh */
#!/bin/sh
# Build the systolic array testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top tb_sa_top -f verilog.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_sa_top > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
